// File: logic/sched_pkg.sv
// shared widths, bundles, exception codes and wakeup helpers; imported by every scheduler module
`default_nettype none

package sched_pkg;

  // ==================================================
  // sizes
  // ==================================================
  localparam int ARCH_NUM = 32;
  localparam int PREG_NUM = 48;
  localparam int WB_WIDTH = 2;
  localparam int FL_DEPTH = PREG_NUM - ARCH_NUM;

  typedef logic [4:0] areg_t;
  typedef logic [5:0] preg_t;
  typedef logic [5:0] tag_t;
  typedef logic [3:0] alu_op_t;

  typedef enum logic [2:0] {
    CLASS_ALU     = 3'd0,
    CLASS_MEM     = 3'd1,
    CLASS_PRIV    = 3'd2,
    CLASS_SYSCALL = 3'd3,
    CLASS_BREAK   = 3'd4
  } instr_class_e;

  // exception codes follow the loongarch estat encoding
  typedef enum logic [5:0] {
    ECODE_INT  = 6'h00,
    ECODE_ADEF = 6'h08,
    ECODE_SYS  = 6'h0b,
    ECODE_BRK  = 6'h0c,
    ECODE_INE  = 6'h0d,
    ECODE_IPE  = 6'h0e
  } ecode_e;

  typedef struct packed {
    logic [2:0] op;
    logic       store;
  } mem_op_t;

  // ==================================================
  // bundles
  // ==================================================
  typedef struct packed {
    instr_class_e cls;
    alu_op_t      alu_op;
    mem_op_t      mem_op;
    areg_t        src0;
    areg_t        src1;
    areg_t        dest;
    logic         invalid;
    logic         fetch_excp;
    ecode_e       fetch_ecode;
  } dec_req_t;

  typedef struct packed {
    logic  valid;
    preg_t preg;
  } wb_t;

  typedef struct packed {
    tag_t  tag;
    preg_t psrc0;
    logic  src0_rdy;
    preg_t psrc1;
    logic  src1_rdy;
    preg_t pdest;
    logic  dest_valid;
  } iq_base_t;

  typedef struct packed {
    logic   valid;
    tag_t   tag;
    ecode_e ecode;
  } excp_rpt_t;

  typedef struct packed {
    logic     valid;
    iq_base_t base;
    alu_op_t  op;
  } alu_issue_t;

  typedef struct packed {
    logic     valid;
    iq_base_t base;
    mem_op_t  op;
  } mem_issue_t;

  // true when any writeback lane this cycle targets p
  function automatic logic wb_hit(preg_t p, wb_t [WB_WIDTH-1:0] wb);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < WB_WIDTH; i++) begin
      if (wb[i].valid && wb[i].preg == p) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic iq_base_t wake_base(iq_base_t b, wb_t [WB_WIDTH-1:0] wb);
    iq_base_t r;
    r = b;
    if (wb_hit(b.psrc0, wb)) begin
      r.src0_rdy = 1'b1;
    end
    if (wb_hit(b.psrc1, wb)) begin
      r.src1_rdy = 1'b1;
    end
    return r;
  endfunction

endpackage

`default_nettype wire

// File: logic/free_list.sv
// circular FIFO of free physical registers; rename pops the head, commit pushes at the tail
`timescale 1ns/100ps
`default_nettype none

module free_list (
  input  wire                clk,
  input  wire                rst_n,
  input  logic               alloc_i,
  output logic               avail_o,
  output sched_pkg::preg_t   head_o,
  input  logic               free_valid_i,
  input  sched_pkg::preg_t   free_preg_i
);
  import sched_pkg::*;

  localparam int PTR_W = $clog2(FL_DEPTH);
  localparam int CNT_W = $clog2(FL_DEPTH + 1);

  preg_t             fifo_q [FL_DEPTH];
  logic [PTR_W-1:0]  head_q;
  logic [PTR_W-1:0]  tail_q;
  logic [CNT_W-1:0]  count_q;

  assign avail_o = (count_q != '0);
  assign head_o  = fifo_q[head_q];

  // reset image holds every register above the architectural set, ascending
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fifo_q[i] <= preg_t'(ARCH_NUM + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(FL_DEPTH);
    end else begin
      if (alloc_i) begin
        head_q <= (head_q == PTR_W'(FL_DEPTH - 1)) ? '0 : head_q + 1'b1;
      end
      if (free_valid_i) begin
        fifo_q[tail_q] <= free_preg_i;
        tail_q <= (tail_q == PTR_W'(FL_DEPTH - 1)) ? '0 : tail_q + 1'b1;
      end
      // simultaneous pop and push leaves the count alone
      if (alloc_i && !free_valid_i) begin
        count_q <= count_q - 1'b1;
      end else if (free_valid_i && !alloc_i) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/rename_table.sv
// speculative arch-to-phys map plus ready bits; combinational lookup, updates on the clock edge
`timescale 1ns/100ps
`default_nettype none

module rename_table (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  sched_pkg::areg_t                        src0_i,
  input  sched_pkg::areg_t                        src1_i,
  input  sched_pkg::areg_t                        dest_i,
  output sched_pkg::preg_t                        psrc0_o,
  output sched_pkg::preg_t                        psrc1_o,
  output logic                                    rdy0_o,
  output logic                                    rdy1_o,
  input  logic                                    map_en_i,
  input  sched_pkg::preg_t                        new_preg_i,
  input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0] wb_i
);
  import sched_pkg::*;

  preg_t               map_q [ARCH_NUM];
  logic [PREG_NUM-1:0] ready_q;

  assign psrc0_o = map_q[src0_i];
  assign psrc1_o = map_q[src1_i];
  assign rdy0_o  = ready_q[map_q[src0_i]];
  assign rdy1_o  = ready_q[map_q[src1_i]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
      ready_q <= '1;
    end else begin
      for (int j = 0; j < WB_WIDTH; j++) begin
        if (wb_i[j].valid) begin
          ready_q[wb_i[j].preg] <= 1'b1;
        end
      end
      // fresh destination is pending until its own writeback
      if (map_en_i) begin
        map_q[dest_i]       <= new_preg_i;
        ready_q[new_preg_i] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/rename_stage.sv
// front of the scheduler: exception check, tagging, rename and one registered slot per queue
`timescale 1ns/100ps
`default_nettype none

module rename_stage (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  logic                                     dec_valid_i,
  input  sched_pkg::dec_req_t                      dec_req_i,
  output logic                                     dec_ready_o,
  input  logic                                     int_i,
  input  logic [1:0]                               plv_i,
  input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0] wb_i,
  input  logic                                     free_valid_i,
  input  sched_pkg::preg_t                         free_preg_i,
  output sched_pkg::excp_rpt_t                     excp_o,
  output logic                                     alu_valid_o,
  output sched_pkg::iq_base_t                      alu_base_o,
  output sched_pkg::alu_op_t                       alu_op_o,
  input  logic                                     alu_ready_i,
  output logic                                     mem_valid_o,
  output sched_pkg::iq_base_t                      mem_base_o,
  output sched_pkg::mem_op_t                       mem_op_o,
  input  logic                                     mem_ready_i
);
  import sched_pkg::*;

  logic     excp_hit;
  ecode_e   excp_code;
  logic     need_dest;
  logic     to_mem;
  logic     slot_free;
  logic     accept;
  logic     dispatch;
  logic     fl_avail;
  preg_t    fl_head;
  preg_t    psrc0;
  preg_t    psrc1;
  logic     rdy0;
  logic     rdy1;
  iq_base_t new_base;
  tag_t     tag_q;
  logic     excp_valid_q;
  tag_t     excp_tag_q;
  ecode_e   excp_code_q;
  logic     alu_valid_q;
  logic     mem_valid_q;

  // ==================================================
  // exception priority
  // ==================================================
  always_comb begin
    excp_hit  = 1'b1;
    excp_code = ECODE_INT;
    if (int_i) begin
      excp_code = ECODE_INT;
    end else if (dec_req_i.fetch_excp) begin
      excp_code = dec_req_i.fetch_ecode;
    end else if (dec_req_i.invalid) begin
      excp_code = ECODE_INE;
    end else if (dec_req_i.cls == CLASS_PRIV && plv_i == 2'b11) begin
      excp_code = ECODE_IPE;
    end else if (dec_req_i.cls == CLASS_SYSCALL) begin
      excp_code = ECODE_SYS;
    end else if (dec_req_i.cls == CLASS_BREAK) begin
      excp_code = ECODE_BRK;
    end else begin
      excp_hit = 1'b0;
    end
  end

  // ==================================================
  // handshake and rename
  // ==================================================
  assign need_dest   = (dec_req_i.dest != '0);
  assign to_mem      = (dec_req_i.cls == CLASS_MEM);
  assign slot_free   = to_mem ? (!mem_valid_q || mem_ready_i) : (!alu_valid_q || alu_ready_i);
  assign dec_ready_o = slot_free && (fl_avail || !need_dest || excp_hit);
  assign accept      = dec_valid_i && dec_ready_o;
  assign dispatch    = accept && !excp_hit;

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (dispatch && need_dest),
    .avail_o      (fl_avail),
    .head_o       (fl_head),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i)
  );

  rename_table u_rename_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .src0_i     (dec_req_i.src0),
    .src1_i     (dec_req_i.src1),
    .dest_i     (dec_req_i.dest),
    .psrc0_o    (psrc0),
    .psrc1_o    (psrc1),
    .rdy0_o     (rdy0),
    .rdy1_o     (rdy1),
    .map_en_i   (dispatch && need_dest),
    .new_preg_i (fl_head),
    .wb_i       (wb_i)
  );

  // r0 and same-cycle writebacks count as ready
  always_comb begin
    new_base.tag        = tag_q;
    new_base.psrc0      = psrc0;
    new_base.src0_rdy   = rdy0 || dec_req_i.src0 == '0 || wb_hit(psrc0, wb_i);
    new_base.psrc1      = psrc1;
    new_base.src1_rdy   = rdy1 || dec_req_i.src1 == '0 || wb_hit(psrc1, wb_i);
    new_base.pdest      = need_dest ? fl_head : '0;
    new_base.dest_valid = need_dest;
  end

  // ==================================================
  // tag, exception report, dispatch slots
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_q        <= '0;
      excp_valid_q <= 1'b0;
      alu_valid_q  <= 1'b0;
      mem_valid_q  <= 1'b0;
    end else begin
      if (accept) begin
        tag_q <= tag_q + tag_t'(1);
      end
      excp_valid_q <= accept && excp_hit;
      if (dispatch && !to_mem) begin
        alu_valid_q <= 1'b1;
      end else if (alu_ready_i) begin
        alu_valid_q <= 1'b0;
      end
      if (dispatch && to_mem) begin
        mem_valid_q <= 1'b1;
      end else if (mem_ready_i) begin
        mem_valid_q <= 1'b0;
      end
    end
  end

  // held slots keep snooping writeback
  always_ff @(posedge clk) begin
    excp_tag_q  <= tag_q;
    excp_code_q <= excp_code;
    if (dispatch && !to_mem) begin
      alu_base_o <= new_base;
      alu_op_o   <= dec_req_i.alu_op;
    end else begin
      alu_base_o <= wake_base(alu_base_o, wb_i);
    end
    if (dispatch && to_mem) begin
      mem_base_o <= new_base;
      mem_op_o   <= dec_req_i.mem_op;
    end else begin
      mem_base_o <= wake_base(mem_base_o, wb_i);
    end
  end

  assign excp_o.valid = excp_valid_q;
  assign excp_o.tag   = excp_tag_q;
  assign excp_o.ecode = excp_code_q;
  assign alu_valid_o  = alu_valid_q;
  assign mem_valid_o  = mem_valid_q;

endmodule

`default_nettype wire

// File: logic/issue_queue.sv
// reservation station for one payload type; wakes on writeback, issues the lowest ready entry
`timescale 1ns/100ps
`default_nettype none

module issue_queue #(
  parameter int  DEPTH     = 4,
  parameter type PAYLOAD_T = logic [3:0]
) (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  logic                                     wr_valid_i,
  input  sched_pkg::iq_base_t                      wr_base_i,
  input  PAYLOAD_T                                 wr_op_i,
  output logic                                     wr_ready_o,
  input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0] wb_i,
  output logic                                     issue_valid_o,
  output sched_pkg::iq_base_t                      issue_base_o,
  output PAYLOAD_T                                 issue_op_o,
  input  logic                                     issue_ready_i
);
  import sched_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0] ent_valid_q;
  iq_base_t         ent_base_q [DEPTH];
  PAYLOAD_T         ent_op_q   [DEPTH];
  iq_base_t         wk_base    [DEPTH];
  logic [DEPTH-1:0] ent_rdy;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             wr_en;
  logic             out_free;
  logic             take;

  // ==================================================
  // wakeup and select
  // ==================================================
  always_comb begin
    free_idx = '0;
    sel_idx  = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      wk_base[i] = wake_base(ent_base_q[i], wb_i);
      ent_rdy[i] = ent_valid_q[i] && wk_base[i].src0_rdy && wk_base[i].src1_rdy;
      // descending scan leaves the lowest index behind
      if (!ent_valid_q[i]) begin
        free_idx = IDX_W'(i);
      end
      if (ent_rdy[i]) begin
        sel_idx = IDX_W'(i);
      end
    end
  end

  assign wr_ready_o = !(&ent_valid_q);
  assign wr_en      = wr_valid_i && wr_ready_o;
  assign out_free   = !issue_valid_o || issue_ready_i;
  assign take       = (|ent_rdy) && out_free;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid_q   <= '0;
      issue_valid_o <= 1'b0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (take && sel_idx == IDX_W'(i)) begin
          ent_valid_q[i] <= 1'b0;
        end else if (wr_en && free_idx == IDX_W'(i)) begin
          ent_valid_q[i] <= 1'b1;
        end
      end
      if (out_free) begin
        issue_valid_o <= |ent_rdy;
      end
    end
  end

  // entry payloads and the output register
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (wr_en && free_idx == IDX_W'(i)) begin
        ent_base_q[i] <= wake_base(wr_base_i, wb_i);
        ent_op_q[i]   <= wr_op_i;
      end else begin
        ent_base_q[i] <= wk_base[i];
      end
    end
    if (take) begin
      issue_base_o <= wk_base[sel_idx];
      issue_op_o   <= ent_op_q[sel_idx];
    end
  end

endmodule

`default_nettype wire

// File: logic/scheduler_top.sv
// scheduler top: rename stage feeding the ALU and memory issue queues
`timescale 1ns/100ps
`default_nettype none

module scheduler_top #(
  parameter int ALU_IQ_DEPTH = 8,
  parameter int MEM_IQ_DEPTH = 4
) (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  logic                                     dec_valid_i,
  input  sched_pkg::dec_req_t                      dec_req_i,
  output logic                                     dec_ready_o,
  input  logic                                     int_i,
  input  logic [1:0]                               plv_i,
  input  sched_pkg::wb_t [sched_pkg::WB_WIDTH-1:0] wb_i,
  input  logic                                     free_valid_i,
  input  sched_pkg::preg_t                         free_preg_i,
  output sched_pkg::alu_issue_t                    alu_issue_o,
  input  logic                                     alu_ready_i,
  output sched_pkg::mem_issue_t                    mem_issue_o,
  input  logic                                     mem_ready_i,
  output sched_pkg::excp_rpt_t                     excp_o
);
  import sched_pkg::*;

  logic     alu_wr_valid;
  logic     alu_wr_ready;
  iq_base_t alu_wr_base;
  alu_op_t  alu_wr_op;
  logic     mem_wr_valid;
  logic     mem_wr_ready;
  iq_base_t mem_wr_base;
  mem_op_t  mem_wr_op;

  rename_stage u_rename (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid_i  (dec_valid_i),
    .dec_req_i    (dec_req_i),
    .dec_ready_o  (dec_ready_o),
    .int_i        (int_i),
    .plv_i        (plv_i),
    .wb_i         (wb_i),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .excp_o       (excp_o),
    .alu_valid_o  (alu_wr_valid),
    .alu_base_o   (alu_wr_base),
    .alu_op_o     (alu_wr_op),
    .alu_ready_i  (alu_wr_ready),
    .mem_valid_o  (mem_wr_valid),
    .mem_base_o   (mem_wr_base),
    .mem_op_o     (mem_wr_op),
    .mem_ready_i  (mem_wr_ready)
  );

  issue_queue #(
    .DEPTH     (ALU_IQ_DEPTH),
    .PAYLOAD_T (alu_op_t)
  ) u_alu_iq (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (alu_wr_valid),
    .wr_base_i     (alu_wr_base),
    .wr_op_i       (alu_wr_op),
    .wr_ready_o    (alu_wr_ready),
    .wb_i          (wb_i),
    .issue_valid_o (alu_issue_o.valid),
    .issue_base_o  (alu_issue_o.base),
    .issue_op_o    (alu_issue_o.op),
    .issue_ready_i (alu_ready_i)
  );

  issue_queue #(
    .DEPTH     (MEM_IQ_DEPTH),
    .PAYLOAD_T (mem_op_t)
  ) u_mem_iq (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (mem_wr_valid),
    .wr_base_i     (mem_wr_base),
    .wr_op_i       (mem_wr_op),
    .wr_ready_o    (mem_wr_ready),
    .wb_i          (wb_i),
    .issue_valid_o (mem_issue_o.valid),
    .issue_base_o  (mem_issue_o.base),
    .issue_op_o    (mem_issue_o.op),
    .issue_ready_i (mem_ready_i)
  );

endmodule

`default_nettype wire

// File: dv/sched_tb.sv
// testbench for scheduler_top; random instruction stream with execution, commit and rename model
`timescale 1ns/100ps
`default_nettype none

module sched_tb;
  import sched_pkg::*;

  localparam int MAX_INFLIGHT = 40;
  localparam int DRAIN_LIMIT  = 2000;

  logic               clk;
  logic               rst_n;
  logic               dec_valid;
  dec_req_t           dec_req;
  logic               dec_ready;
  logic               int_s;
  logic [1:0]         plv;
  wb_t [WB_WIDTH-1:0] wb;
  logic               free_valid;
  preg_t              free_preg;
  alu_issue_t         alu_issue;
  logic               alu_ready;
  mem_issue_t         mem_issue;
  logic               mem_ready;
  excp_rpt_t          excp;

  // ==================================================
  // reference model state
  // ==================================================
  preg_t               m_map [ARCH_NUM];
  logic [PREG_NUM-1:0] m_ready;
  preg_t               m_free [$];
  tag_t                m_tag;

  // one record per tag while the instruction is in flight
  logic         r_busy   [64];
  logic         r_excp   [64];
  logic         r_issued [64];
  logic         r_done   [64];
  instr_class_e r_cls    [64];
  iq_base_t     r_base   [64];
  alu_op_t      r_alu    [64];
  mem_op_t      r_mem    [64];
  preg_t        r_old    [64];
  tag_t         commit_q [$];
  tag_t         exec_tag [$];
  int           exec_due [$];

  int          seed = 32'h62874fce;
  int          cycle;
  int          errors;
  int          checks;
  int          accepts;
  int          exceptions;
  int          issues;
  int          alloc_count;
  logic        gen_en;
  logic        commit_en;
  logic        dest_only;
  logic        req_pending;
  logic        last_accept;
  logic        exp_excp;
  tag_t        exp_excp_tag;
  ecode_e      exp_excp_code;
  logic        alu_hold;
  logic        mem_hold;
  logic [63:0] alu_prev;
  logic [63:0] mem_prev;

  scheduler_top #(
    .ALU_IQ_DEPTH (8),
    .MEM_IQ_DEPTH (4)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid_i  (dec_valid),
    .dec_req_i    (dec_req),
    .dec_ready_o  (dec_ready),
    .int_i        (int_s),
    .plv_i        (plv),
    .wb_i         (wb),
    .free_valid_i (free_valid),
    .free_preg_i  (free_preg),
    .alu_issue_o  (alu_issue),
    .alu_ready_i  (alu_ready),
    .mem_issue_o  (mem_issue),
    .mem_ready_i  (mem_ready),
    .excp_o       (excp)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // interrupt, fetch fault, INE, IPE, SYS, BRK in that order
  function automatic logic expect_excp(input dec_req_t q, input logic intr,
                                       input logic [1:0] lvl, output ecode_e code);
    expect_excp = 1'b1;
    code        = ECODE_INT;
    if (intr) begin
      code = ECODE_INT;
    end else if (q.fetch_excp) begin
      code = q.fetch_ecode;
    end else if (q.invalid) begin
      code = ECODE_INE;
    end else if (q.cls == CLASS_PRIV && lvl == 2'b11) begin
      code = ECODE_IPE;
    end else if (q.cls == CLASS_SYSCALL) begin
      code = ECODE_SYS;
    end else if (q.cls == CLASS_BREAK) begin
      code = ECODE_BRK;
    end else begin
      expect_excp = 1'b0;
    end
  endfunction

  function automatic dec_req_t random_request(input logic plain);
    dec_req_t    q;
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = rand_word();
    r1 = rand_word();
    case (r0[3:0])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: q.cls = CLASS_ALU;
      4'd6, 4'd7, 4'd8, 4'd9: q.cls = CLASS_MEM;
      4'd10, 4'd11: q.cls = CLASS_PRIV;
      4'd12: q.cls = CLASS_SYSCALL;
      4'd13: q.cls = CLASS_BREAK;
      default: q.cls = CLASS_ALU;
    endcase
    q.alu_op       = r0[7:4];
    q.mem_op.op    = r0[10:8];
    q.mem_op.store = r0[11];
    q.src0         = r0[16:12];
    q.src1         = r0[21:17];
    q.dest         = r0[26:22];
    q.invalid      = (r1[4:0] == 5'd0);
    q.fetch_excp   = (r1[9:5] == 5'd0);
    q.fetch_ecode  = ECODE_ADEF;
    // register-writing stream that never traps
    if (plain) begin
      q.cls        = CLASS_ALU;
      q.invalid    = 1'b0;
      q.fetch_excp = 1'b0;
      if (q.dest == '0) begin
        q.dest = 5'd1;
      end
    end
    return q;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // ==================================================
  // model updates
  // ==================================================
  task automatic model_accept();
    tag_t     t;
    ecode_e   code;
    logic     hit;
    iq_base_t b;
    t     = m_tag;
    m_tag = m_tag + tag_t'(1);
    hit   = expect_excp(dec_req, int_s, plv, code);
    accepts++;
    r_busy[t]   = 1'b1;
    r_excp[t]   = hit;
    r_done[t]   = hit;
    r_issued[t] = 1'b0;
    commit_q.push_back(t);
    if (hit) begin
      exceptions++;
      exp_excp      = 1'b1;
      exp_excp_tag  = t;
      exp_excp_code = code;
    end else begin
      b       = '0;
      b.tag   = t;
      b.psrc0 = m_map[dec_req.src0];
      b.psrc1 = m_map[dec_req.src1];
      if (dec_req.dest != '0) begin
        b.dest_valid = 1'b1;
        r_old[t]     = m_map[dec_req.dest];
        alloc_count++;
        if (m_free.size() == 0) begin
          report_error("instruction with a destination accepted while no register was free");
        end else begin
          b.pdest             = m_free.pop_front();
          m_map[dec_req.dest] = b.pdest;
          m_ready[b.pdest]    = 1'b0;
        end
      end
      r_base[t] = b;
      r_cls[t]  = dec_req.cls;
      r_alu[t]  = dec_req.alu_op;
      r_mem[t]  = dec_req.mem_op;
    end
  endtask

  task automatic new_issue(input string port, input logic on_mem, input iq_base_t b,
                           input logic [3:0] op);
    tag_t t;
    t = b.tag;
    if (!r_busy[t] || r_excp[t] || r_issued[t]) begin
      report_error($sformatf("%s issued tag %0d, which was not waiting to issue", port, t));
    end else begin
      r_issued[t] = 1'b1;
      issues++;
      check_value({port, " on memory port"}, 64'(on_mem), 64'(r_cls[t] == CLASS_MEM));
      check_value({port, ".base.psrc0"}, 64'(b.psrc0), 64'(r_base[t].psrc0));
      check_value({port, ".base.psrc1"}, 64'(b.psrc1), 64'(r_base[t].psrc1));
      check_value({port, ".base.pdest"}, 64'(b.pdest), 64'(r_base[t].pdest));
      check_value({port, ".base.dest_valid"}, 64'(b.dest_valid), 64'(r_base[t].dest_valid));
      check_value({port, ".base.src0_rdy"}, 64'(b.src0_rdy), 64'd1);
      check_value({port, ".base.src1_rdy"}, 64'(b.src1_rdy), 64'd1);
      check_value({port, ".op"}, 64'(op), on_mem ? 64'(r_mem[t]) : 64'(r_alu[t]));
      check_value({port, " src0 ready"}, 64'(m_ready[r_base[t].psrc0]), 64'd1);
      check_value({port, " src1 ready"}, 64'(m_ready[r_base[t].psrc1]), 64'd1);
    end
  endtask

  task automatic schedule_exec(input tag_t t);
    logic [31:0] r;
    r = rand_word();
    if (r_busy[t] && r_issued[t] && !r_excp[t]) begin
      exec_tag.push_back(t);
      exec_due.push_back(cycle + 1 + int'(r[1:0]));
    end
  endtask

  // ==================================================
  // per-cycle sequence
  // ==================================================
  task automatic observe_outputs();
    check_value("excp_o.valid", 64'(excp.valid), 64'(exp_excp));
    if (exp_excp && excp.valid) begin
      check_value("excp_o.tag", 64'(excp.tag), 64'(exp_excp_tag));
      check_value("excp_o.ecode", 64'(excp.ecode), 64'(exp_excp_code));
    end
    exp_excp = 1'b0;
    if (alu_hold) begin
      check_value("alu_issue_o held", 64'(alu_issue), alu_prev);
    end else if (alu_issue.valid) begin
      new_issue("alu_issue_o", 1'b0, alu_issue.base, alu_issue.op);
    end
    if (mem_hold) begin
      check_value("mem_issue_o held", 64'(mem_issue), mem_prev);
    end else if (mem_issue.valid) begin
      new_issue("mem_issue_o", 1'b1, mem_issue.base, mem_issue.op);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    int          lanes;
    int          i;
    tag_t        t;
    r     = rand_word();
    wb    = '0;
    lanes = 0;
    i     = 0;
    // finished execution, one register per writeback lane
    while (i < exec_tag.size()) begin
      t = exec_tag[i];
      if (exec_due[i] > cycle || (r_base[t].dest_valid && lanes == WB_WIDTH)) begin
        i++;
      end else begin
        if (r_base[t].dest_valid) begin
          wb[lanes[0]].valid       = 1'b1;
          wb[lanes[0]].preg        = r_base[t].pdest;
          m_ready[r_base[t].pdest] = 1'b1;
          lanes++;
        end
        r_done[t] = 1'b1;
        exec_tag.delete(i);
        exec_due.delete(i);
      end
    end
    // in-order commit returns the previous mapping
    free_valid = 1'b0;
    free_preg  = '0;
    if (commit_en && commit_q.size() > 0 && r_done[commit_q[0]]) begin
      t         = commit_q.pop_front();
      r_busy[t] = 1'b0;
      if (!r_excp[t] && r_base[t].dest_valid) begin
        free_valid = 1'b1;
        free_preg  = r_old[t];
        m_free.push_back(r_old[t]);
      end
    end
    alu_ready = (r[1:0] != 2'd0);
    mem_ready = (r[3:2] != 2'd0);
    if (!gen_en) begin
      dec_valid = 1'b0;
    end else if (!req_pending) begin
      dec_valid = (r[5:4] != 2'd0) && (commit_q.size() < MAX_INFLIGHT);
      dec_req   = random_request(dest_only);
      int_s     = !dest_only && (r[15:10] == 6'd0);
      plv       = dest_only ? 2'd0 : r[17:16];
    end
  endtask

  task automatic capture_handshakes();
    ecode_e code;
    logic   hit;
    if (alu_issue.valid && alu_ready) begin
      schedule_exec(alu_issue.base.tag);
    end
    if (mem_issue.valid && mem_ready) begin
      schedule_exec(mem_issue.base.tag);
    end
    alu_hold = alu_issue.valid && !alu_ready;
    mem_hold = mem_issue.valid && !mem_ready;
    alu_prev = 64'(alu_issue);
    mem_prev = 64'(mem_issue);
    hit      = expect_excp(dec_req, int_s, plv, code);
    if (dec_valid && !hit && dec_req.dest != '0 && m_free.size() == 0) begin
      check_value("dec_ready_o with free list empty", 64'(dec_ready), 64'd0);
    end
    last_accept = dec_valid && dec_ready;
    req_pending = dec_valid && !dec_ready;
    if (last_accept) begin
      model_accept();
    end
  endtask

  task automatic step();
    @(negedge clk);
    cycle++;
    observe_outputs();
    drive_inputs();
    #1;
    capture_handshakes();
  endtask

  task automatic drain(input string name);
    int n;
    gen_en    = 1'b0;
    commit_en = 1'b1;
    n         = 0;
    while (commit_q.size() > 0 && n < DRAIN_LIMIT) begin
      step();
      n++;
    end
    if (commit_q.size() > 0) begin
      report_error($sformatf("%s timed out with %0d instructions outstanding",
                             name, commit_q.size()));
    end
  endtask

  task automatic finish_test(input string name, input int base);
    $display("test %-8s %s, %0d errors", name, (errors == base) ? "ok" : "bad", errors - base);
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    int base;
    int stall;
    int n;
    clk         = 1'b0;
    rst_n       = 1'b0;
    dec_valid   = 1'b0;
    dec_req     = '0;
    int_s       = 1'b0;
    plv         = 2'd0;
    wb          = '0;
    free_valid  = 1'b0;
    free_preg   = '0;
    alu_ready   = 1'b0;
    mem_ready   = 1'b0;
    cycle       = 0;
    errors      = 0;
    checks      = 0;
    accepts     = 0;
    exceptions  = 0;
    issues      = 0;
    alloc_count = 0;
    gen_en      = 1'b0;
    commit_en   = 1'b1;
    dest_only   = 1'b0;
    req_pending = 1'b0;
    last_accept = 1'b0;
    exp_excp    = 1'b0;
    alu_hold    = 1'b0;
    mem_hold    = 1'b0;
    m_tag       = '0;
    m_ready     = '1;
    for (int i = 0; i < ARCH_NUM; i++) begin
      m_map[i] = preg_t'(i);
    end
    for (int i = ARCH_NUM; i < PREG_NUM; i++) begin
      m_free.push_back(preg_t'(i));
    end
    for (int i = 0; i < 64; i++) begin
      r_busy[i]   = 1'b0;
      r_excp[i]   = 1'b0;
      r_issued[i] = 1'b0;
      r_done[i]   = 1'b0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    base = errors;
    #1;
    check_value("dec_ready_o after reset", 64'(dec_ready), 64'd1);
    check_value("alu_issue_o.valid after reset", 64'(alu_issue.valid), 64'd0);
    check_value("mem_issue_o.valid after reset", 64'(mem_issue.valid), 64'd0);
    check_value("excp_o.valid after reset", 64'(excp.valid), 64'd0);
    finish_test("reset", base);

    // mixed classes, traps and back-pressure
    base   = errors;
    gen_en = 1'b1;
    repeat (3000) step();
    drain("random drain");
    finish_test("random", base);

    // run the free list dry, then recycle
    base        = errors;
    alloc_count = 0;
    commit_en   = 1'b0;
    dest_only   = 1'b1;
    gen_en      = 1'b1;
    stall       = 0;
    n           = 0;
    while (stall < 40 && n < 400) begin
      step();
      n++;
      stall = req_pending ? stall + 1 : 0;
    end
    if (stall < 40) begin
      report_error("dec_ready_o did not stay low while commits were withheld");
    end
    check_value("allocations before stall", 64'(alloc_count), 64'(FL_DEPTH));
    commit_en = 1'b1;
    n         = 0;
    while (!last_accept && n < 200) begin
      step();
      n++;
    end
    if (!last_accept) begin
      report_error("dec_ready_o did not rise after registers were returned");
    end
    repeat (500) step();
    drain("exhaust drain");
    dest_only = 1'b0;
    finish_test("exhaust", base);

    $display("summary: %0d checks, %0d errors, %0d accepted, %0d exceptions, %0d issued",
             checks, errors, accepts, exceptions, issues);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
logic/sched_pkg.sv
logic/free_list.sv
logic/rename_table.sv
logic/rename_stage.sv
logic/issue_queue.sv
logic/scheduler_top.sv
dv/sched_tb.sv

// File: Makefile
TOP := sched_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

lint:
	verilator --lint-only -Wall --top-module scheduler_top logic/sched_pkg.sv \
		logic/free_list.sv logic/rename_table.sv logic/rename_stage.sv \
		logic/issue_queue.sv logic/scheduler_top.sv

clean:
	rm -rf obj_dir
